// ==== hdl/sdramPkg.sv ====
// Shared SDRAM controller types, pin command encodings and timing constants; import with sdramPkg::*

package sdramPkg;

    // ====================
    // Types
    // ====================

    // Word address as bank[21:20], row[19:8], column[7:0]
    typedef logic [21:0] wordAddrT;

    typedef logic [15:0] dataT;     // One SDRAM data word
    typedef logic [7:0]  lengthT;   // Burst length, 0 disables a port
    typedef logic [6:0]  countT;    // FIFO fill count, holds 0..64

    // Pin command as {RAS_N, CAS_N, WE_N}
    typedef enum logic [2:0] {
        nop         = 3'b111,
        active      = 3'b011,
        read        = 3'b101,
        write       = 3'b100,
        burstTerm   = 3'b110,
        precharge   = 3'b010,
        autoRefresh = 3'b001,
        loadMode    = 3'b000
    } sdrCmdT;

    // ====================
    // Timing in clock cycles
    // ====================

    localparam int casLatency = 2;
    localparam int tRcd       = 2;   // Active to read or write
    localparam int tRp        = 2;   // Precharge to active
    localparam int tRfc       = 7;   // Refresh cycle time

    // Mode register contents
    // [2:0] full page, [3] sequential, [6:4] CAS 2, [9] burst writes
    localparam logic [11:0] modeWord = 12'b00_0_00_010_0_111;

endpackage

// ==== hdl/burstFifo.sv ====
// Show-ahead single-clock FIFO with fill count, instantiated for the write and the read side
`timescale 1ns/10ps

module burstFifo
    import sdramPkg::*;
#(
    parameter int fifoDepth = 64
)
(
    input  logic  CLK,
    input  logic  RESET_N,
    input  logic  clear,      // Empties the FIFO in one cycle
    input  logic  push,
    input  dataT  pushData,
    input  logic  pop,
    output dataT  headData,   // Oldest word, valid while not empty
    output countT count,
    output logic  full,
    output logic  empty
);

    localparam int ptrW = $clog2(fifoDepth);

    dataT           mem [fifoDepth];
    logic [ptrW-1:0] wrPtr;
    logic [ptrW-1:0] rdPtr;
    logic           doPush;
    logic           doPop;

    assign doPush = push && !full;    // Overflow dropped
    assign doPop  = pop && !empty;    // Underflow ignored

    // Pointers and count
    always_ff @(posedge CLK or negedge RESET_N)
    begin
        if (!RESET_N)
        begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end
        else if (clear)
        begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end
        else
        begin
            if (doPush)
                wrPtr <= (wrPtr == ptrW'(fifoDepth - 1)) ? '0 : wrPtr + 1'b1;
            if (doPop)
                rdPtr <= (rdPtr == ptrW'(fifoDepth - 1)) ? '0 : rdPtr + 1'b1;
            case ({doPush, doPop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;   // Both or neither
            endcase
        end
    end

    // Storage array
    always_ff @(posedge CLK)
    begin
        if (doPush)
            mem[wrPtr] <= pushData;
    end

    assign headData = mem[rdPtr];   // Show-ahead
    assign full     = (count == countT'(fifoDepth));
    assign empty    = (count == '0);

endmodule

// ==== hdl/burstScheduler.sv ====
// Burst scheduler that tracks the port addresses and picks the next SDRAM burst from FIFO levels
`timescale 1ns/10ps

module burstScheduler
    import sdramPkg::*;
#(
    parameter int fifoDepth = 64
)
(
    input  logic     CLK,
    input  logic     RESET_N,
    // Write port setup
    input  logic     wrLoad,
    input  wordAddrT wrStartAddr,
    input  wordAddrT wrMaxAddr,
    input  lengthT   wrLength,
    // Read port setup
    input  logic     rdLoad,
    input  wordAddrT rdStartAddr,
    input  wordAddrT rdMaxAddr,
    input  lengthT   rdLength,
    // FIFO levels
    input  countT    wrCount,
    input  countT    rdCount,
    // Burst request to the sequencer
    output logic     burstReq,
    output logic     burstWrite,
    output wordAddrT burstAddr,
    output lengthT   burstLen,
    input  logic     burstAck,
    input  logic     burstDone
);

    wordAddrT wrOfs;       // Write offset from start address
    wordAddrT rdOfs;       // Read offset from start address
    logic     holding;     // Request through burstDone
    logic     wrStale;     // Write port reloaded during its own burst
    logic     rdStale;
    logic     wrReady;
    logic     rdReady;

    // Offset after a burst of len words wraps to zero when the next one would pass maxAddr
    function automatic wordAddrT advanceOfs(wordAddrT startAddr, wordAddrT maxAddr,
                                            wordAddrT ofs, lengthT len);
        logic [22:0] nextEnd;
        // Last word of the next burst
        nextEnd = 23'(startAddr) + 23'(ofs) + 23'(len) + 23'(len) - 23'd1;
        if (nextEnd > 23'(maxAddr))
            advanceOfs = '0;
        else
            advanceOfs = ofs + wordAddrT'(len);
    endfunction

    assign wrReady = (wrLength != '0) && (wrCount >= wrLength);   // Full burst waiting
    assign rdReady = (rdLength != '0)
                     && ((int'(rdCount) + int'(rdLength)) <= fifoDepth);   // Room for a burst

    // ====================
    // Request and port addresses
    // ====================
    always_ff @(posedge CLK or negedge RESET_N)
    begin
        if (!RESET_N)
        begin
            wrOfs      <= '0;
            rdOfs      <= '0;
            holding    <= 1'b0;
            burstReq   <= 1'b0;
            burstWrite <= 1'b0;
            wrStale    <= 1'b0;
            rdStale    <= 1'b0;
        end
        else
        begin
            if (burstAck)
                burstReq <= 1'b0;
            // New burst with write first
            if (!holding && !wrLoad && !rdLoad && (wrReady || rdReady))
            begin
                holding    <= 1'b1;
                burstReq   <= 1'b1;
                burstWrite <= wrReady;
            end
            if (burstDone)
                holding <= 1'b0;

            // Write port
            if (wrLoad)
            begin
                wrOfs   <= '0;
                wrStale <= holding && burstWrite && !burstDone;
            end
            else if (burstDone && burstWrite)
            begin
                wrOfs   <= wrStale ? '0 : advanceOfs(wrStartAddr, wrMaxAddr, wrOfs, burstLen);
                wrStale <= 1'b0;
            end

            // Read port
            if (rdLoad)
            begin
                rdOfs   <= '0;
                rdStale <= holding && !burstWrite && !burstDone;
            end
            else if (burstDone && !burstWrite)
            begin
                rdOfs   <= rdStale ? '0 : advanceOfs(rdStartAddr, rdMaxAddr, rdOfs, burstLen);
                rdStale <= 1'b0;
            end
        end
    end

    // Burst address and length frozen while a burst is held
    always_ff @(posedge CLK)
    begin
        if (!holding)
        begin
            burstAddr <= wrReady ? wrStartAddr + wrOfs : rdStartAddr + rdOfs;
            burstLen  <= wrReady ? wrLength : rdLength;
        end
    end

endmodule

// ==== hdl/sdramSequencer.sv ====
// SDRAM command sequencer for power-up init, auto-refresh and page-mode bursts on registered pins
`timescale 1ns/10ps

module sdramSequencer
    import sdramPkg::*;
#(
    parameter int refreshInterval = 390,
    parameter int initDelay       = 100
)
(
    input  logic        CLK,
    input  logic        RESET_N,
    // Burst from the scheduler
    input  logic        burstReq,
    input  logic        burstWrite,
    input  wordAddrT    burstAddr,
    input  lengthT      burstLen,
    output logic        burstAck,
    output logic        burstDone,
    // FIFO side
    output logic        wrPop,
    input  dataT        wrHead,
    output logic        rdPush,
    output dataT        rdPushData,
    // SDRAM pins
    output logic [11:0] sdrAddr,
    output logic [1:0]  sdrBank,
    output logic        sdrCsN,
    output logic        sdrCke,
    output logic        sdrRasN,
    output logic        sdrCasN,
    output logic        sdrWeN,
    output logic [1:0]  sdrDqm,
    output dataT        sdrDqOut,
    output logic        sdrDqOe,
    input  dataT        sdrDqIn
);

    typedef enum logic [2:0] {
        stInit,
        stIdle,
        stRefresh,
        stActivate,
        stData,
        stTerminate,
        stPrecharge
    } seqStateT;

    // Init schedule, counted from reset release
    localparam logic [15:0] preAllAt = 16'(initDelay - 1);
    localparam logic [15:0] refAt1   = preAllAt + 16'(tRp);
    localparam logic [15:0] refAt2   = refAt1 + 16'(tRfc);
    localparam logic [15:0] modeAt   = refAt2 + 16'(tRfc);
    localparam logic [15:0] initEnd  = modeAt + 16'd2;   // Mode register set time

    seqStateT    state;
    sdrCmdT      cmd;
    logic [15:0] cnt;          // Cycle within init or burst, 0 on the active cycle
    logic [15:0] refTimer;
    logic [15:0] nextCyc;      // Cycle being set up on the pins
    logic [15:0] lenW;
    logic [15:0] preAt;        // Precharge cycle of this burst
    logic        refPending;
    logic        isWrite;
    lengthT      lenReg;
    logic [7:0]  colReg;
    logic        inBurst;
    logic        dataNext;
    logic        pushNext;
    logic        dqOe;

    assign {sdrRasN, sdrCasN, sdrWeN} = cmd;
    assign sdrDqOut = wrHead;   // Head word on DQ, popped each data cycle
    assign sdrDqOe  = dqOe;
    assign wrPop    = dqOe;

    // ====================
    // Burst window decode
    // ====================
    always_comb
    begin
        inBurst  = state inside {stActivate, stData, stTerminate, stPrecharge};
        nextCyc  = cnt + 16'd1;
        lenW     = 16'(lenReg);
        // Writes precharge right after BST, reads after the last word
        preAt    = isWrite ? 16'(tRcd) + lenW + 16'd1 : 16'(tRcd + casLatency) + lenW;
        // DQM and write data share one window, DQM read latency is CAS 2
        dataNext = inBurst && (nextCyc >= 16'(tRcd)) && (nextCyc < 16'(tRcd) + lenW);
        // One cycle behind the pins for the capture register
        pushNext = inBurst && !isWrite && (nextCyc > 16'(tRcd + casLatency))
                   && (nextCyc <= 16'(tRcd + casLatency) + lenW);
    end

    // ====================
    // Sequencer FSM
    // ====================
    always_ff @(posedge CLK or negedge RESET_N)
    begin
        if (!RESET_N)
        begin
            state      <= stInit;
            cmd        <= nop;
            cnt        <= '0;
            refTimer   <= '0;
            refPending <= 1'b0;
            sdrCke     <= 1'b0;
            sdrCsN     <= 1'b1;   // Deselected until init starts
            sdrAddr    <= '0;
            sdrBank    <= '0;
            sdrDqm     <= 2'b11;
            dqOe       <= 1'b0;
            rdPush     <= 1'b0;
            burstAck   <= 1'b0;
            burstDone  <= 1'b0;
            isWrite    <= 1'b0;
            lenReg     <= '0;
            colReg     <= '0;
        end
        else
        begin
            sdrCke    <= 1'b1;
            cmd       <= nop;     // Default every cycle
            burstAck  <= 1'b0;
            burstDone <= 1'b0;
            sdrDqm    <= dataNext ? 2'b00 : 2'b11;
            dqOe      <= dataNext && isWrite;
            rdPush    <= pushNext;

            case (state)
                stInit:
                begin
                    cnt <= cnt + 16'd1;
                    if (cnt == preAllAt)
                    begin
                        sdrCsN  <= 1'b0;
                        cmd     <= precharge;
                        sdrAddr <= 12'h400;   // A10 high, all banks
                    end
                    else if ((cnt == refAt1) || (cnt == refAt2))
                        cmd <= autoRefresh;
                    else if (cnt == modeAt)
                    begin
                        cmd     <= loadMode;
                        sdrAddr <= modeWord;
                        sdrBank <= '0;
                    end
                    else if (cnt == initEnd)
                        state <= stIdle;
                end

                stIdle:
                begin
                    cnt <= '0;
                    if (refPending)   // Refresh before any burst
                    begin
                        cmd        <= autoRefresh;
                        refPending <= 1'b0;
                        state      <= stRefresh;
                    end
                    else if (burstReq)
                    begin
                        cmd      <= active;
                        sdrBank  <= burstAddr[21:20];
                        sdrAddr  <= burstAddr[19:8];   // Row
                        colReg   <= burstAddr[7:0];
                        lenReg   <= burstLen;
                        isWrite  <= burstWrite;
                        burstAck <= 1'b1;
                        state    <= stActivate;
                    end
                end

                stRefresh:
                begin
                    cnt <= cnt + 16'd1;
                    if (nextCyc == 16'(tRfc))
                        state <= stIdle;
                end

                stActivate:
                begin
                    cnt <= cnt + 16'd1;
                    if (nextCyc == 16'(tRcd))
                    begin
                        cmd     <= isWrite ? write : read;
                        sdrAddr <= {4'b0000, colReg};   // A10 low, no auto precharge
                        state   <= stData;
                    end
                end

                stData:
                begin
                    cnt <= cnt + 16'd1;
                    if (nextCyc == 16'(tRcd) + lenW)
                    begin
                        cmd   <= burstTerm;   // Ends the full-page burst
                        state <= stTerminate;
                    end
                end

                stTerminate:
                begin
                    cnt <= cnt + 16'd1;
                    if (nextCyc == preAt)
                    begin
                        cmd     <= precharge;
                        sdrAddr <= 12'h400;
                        state   <= stPrecharge;
                    end
                end

                stPrecharge:
                begin
                    cnt <= cnt + 16'd1;
                    if (nextCyc == preAt + 16'(tRp))
                    begin
                        burstDone <= 1'b1;
                        state     <= stIdle;
                    end
                end

                default: state <= stIdle;
            endcase

            // Refresh timer, runs once init is over
            if (state != stInit)
            begin
                if (refTimer == 16'(refreshInterval - 1))
                begin
                    refTimer   <= '0;
                    refPending <= 1'b1;
                end
                else
                    refTimer <= refTimer + 16'd1;
            end
        end
    end

    // Read data capture register
    always_ff @(posedge CLK)
    begin
        rdPushData <= sdrDqIn;
    end

endmodule

// ==== hdl/sdramCtrlTop.sv ====
// Top level of the single-clock SDRAM controller with one write port and one read port
`timescale 1ns/10ps

module sdramCtrlTop
    import sdramPkg::*;
#(
    parameter int fifoDepth       = 64,
    parameter int refreshInterval = 390,
    parameter int initDelay       = 100
)
(
    input  logic        CLK,
    input  logic        RESET_N,
    // Write port
    input  dataT        wrData,
    input  logic        wrValid,
    output logic        wrFull,
    input  logic        wrLoad,        // FIFO clear and address restart
    input  wordAddrT    wrStartAddr,
    input  wordAddrT    wrMaxAddr,
    input  lengthT      wrLength,
    // Read port
    output dataT        rdData,
    input  logic        rdPop,
    output logic        rdEmpty,
    input  logic        rdLoad,
    input  wordAddrT    rdStartAddr,
    input  wordAddrT    rdMaxAddr,
    input  lengthT      rdLength,
    // SDRAM pins
    output logic [11:0] sdrAddr,
    output logic [1:0]  sdrBank,
    output logic        sdrCsN,
    output logic        sdrCke,
    output logic        sdrRasN,
    output logic        sdrCasN,
    output logic        sdrWeN,
    output logic [1:0]  sdrDqm,
    output dataT        sdrDqOut,
    output logic        sdrDqOe,
    input  dataT        sdrDqIn
);

    countT    wrCount;
    countT    rdCount;
    dataT     wrHead;
    logic     wrPop;
    logic     rdPush;
    dataT     rdPushData;
    logic     burstReq;
    logic     burstWrite;
    wordAddrT burstAddr;
    lengthT   burstLen;
    logic     burstAck;
    logic     burstDone;

    // ====================
    // FIFOs
    // ====================
    burstFifo #(.fifoDepth(fifoDepth)) wrFifo (
        .CLK      (CLK),
        .RESET_N  (RESET_N),
        .clear    (wrLoad),
        .push     (wrValid),
        .pushData (wrData),
        .pop      (wrPop),
        .headData (wrHead),
        .count    (wrCount),
        .full     (wrFull),
        .empty    ()
    );

    burstFifo #(.fifoDepth(fifoDepth)) rdFifo (
        .CLK      (CLK),
        .RESET_N  (RESET_N),
        .clear    (rdLoad),
        .push     (rdPush),
        .pushData (rdPushData),
        .pop      (rdPop),
        .headData (rdData),
        .count    (rdCount),
        .full     (),
        .empty    (rdEmpty)
    );

    // ====================
    // Scheduling and pins
    // ====================
    burstScheduler #(.fifoDepth(fifoDepth)) scheduler (
        .CLK         (CLK),
        .RESET_N     (RESET_N),
        .wrLoad      (wrLoad),
        .wrStartAddr (wrStartAddr),
        .wrMaxAddr   (wrMaxAddr),
        .wrLength    (wrLength),
        .rdLoad      (rdLoad),
        .rdStartAddr (rdStartAddr),
        .rdMaxAddr   (rdMaxAddr),
        .rdLength    (rdLength),
        .wrCount     (wrCount),
        .rdCount     (rdCount),
        .burstReq    (burstReq),
        .burstWrite  (burstWrite),
        .burstAddr   (burstAddr),
        .burstLen    (burstLen),
        .burstAck    (burstAck),
        .burstDone   (burstDone)
    );

    sdramSequencer #(
        .refreshInterval (refreshInterval),
        .initDelay       (initDelay)
    ) sequencer (
        .CLK        (CLK),
        .RESET_N    (RESET_N),
        .burstReq   (burstReq),
        .burstWrite (burstWrite),
        .burstAddr  (burstAddr),
        .burstLen   (burstLen),
        .burstAck   (burstAck),
        .burstDone  (burstDone),
        .wrPop      (wrPop),
        .wrHead     (wrHead),
        .rdPush     (rdPush),
        .rdPushData (rdPushData),
        .sdrAddr    (sdrAddr),
        .sdrBank    (sdrBank),
        .sdrCsN     (sdrCsN),
        .sdrCke     (sdrCke),
        .sdrRasN    (sdrRasN),
        .sdrCasN    (sdrCasN),
        .sdrWeN     (sdrWeN),
        .sdrDqm     (sdrDqm),
        .sdrDqOut   (sdrDqOut),
        .sdrDqOe    (sdrDqOe),
        .sdrDqIn    (sdrDqIn)
    );

endmodule

// ==== sim/sdramModel.sv ====
// Behavioral SDRAM that decodes pin commands and serves full-page bursts with CAS latency in simulation
`timescale 1ns/10ps

module sdramModel
    import sdramPkg::*;
(
    input  logic        CLK,
    input  logic [11:0] sdrAddr,
    input  logic [1:0]  sdrBank,
    input  logic        sdrCsN,
    input  logic        sdrCke,
    input  logic        sdrRasN,
    input  logic        sdrCasN,
    input  logic        sdrWeN,
    input  logic [1:0]  sdrDqm,
    input  dataT        sdrDqOut,
    input  logic        sdrDqOe,
    output dataT        sdrDqIn
);

    dataT        mem [wordAddrT];       // Sparse storage
    dataT        pipe [casLatency];     // Read latency line
    logic [11:0] openRow [4];
    logic [1:0]  burstBank;
    logic [7:0]  col;                   // Next column of the open burst
    logic        rdOn;
    logic        wrOn;
    sdrCmdT      cmd;
    wordAddrT    addr;
    dataT        fetched;

    assign cmd     = (sdrCsN || !sdrCke) ? nop : sdrCmdT'({sdrRasN, sdrCasN, sdrWeN});
    assign sdrDqIn = pipe[casLatency-1];

    initial
    begin
        rdOn = 1'b0;
        wrOn = 1'b0;
        col  = '0;
        for (int i = 0; i < casLatency; i++)
            pipe[i] = '0;
    end

    always @(posedge CLK)
    begin
        fetched = '0;
        case (cmd)
            active: openRow[sdrBank] <= sdrAddr;
            read:
            begin
                addr    = {sdrBank, openRow[sdrBank], sdrAddr[7:0]};
                fetched = mem.exists(addr) ? mem[addr] : '0;   // First word of the burst
                burstBank <= sdrBank;
                col       <= sdrAddr[7:0] + 8'd1;
                rdOn      <= 1'b1;
                wrOn      <= 1'b0;
            end
            write:
            begin
                addr = {sdrBank, openRow[sdrBank], sdrAddr[7:0]};
                if (sdrDqOe && (sdrDqm == 2'b00))
                    mem[addr] = sdrDqOut;   // Data comes with the command
                burstBank <= sdrBank;
                col       <= sdrAddr[7:0] + 8'd1;
                wrOn      <= 1'b1;
                rdOn      <= 1'b0;
            end
            burstTerm, precharge:
            begin
                rdOn <= 1'b0;
                wrOn <= 1'b0;
            end
            default:
            begin
                addr = {burstBank, openRow[burstBank], col};
                if (wrOn && sdrDqOe)
                begin
                    if (sdrDqm == 2'b00)
                        mem[addr] = sdrDqOut;
                    col <= col + 8'd1;          // Wraps within the page
                end
                else if (rdOn)
                begin
                    fetched = mem.exists(addr) ? mem[addr] : '0;
                    col <= col + 8'd1;
                end
            end
        endcase
        if (sdrDqm != 2'b00)
            fetched = 'x;   // DQM blanks the word it meets two cycles later
        pipe[0] <= fetched;
        for (int i = 1; i < casLatency; i++)
            pipe[i] <= pipe[i-1];
    end

endmodule

// ==== sim/sdramCtrl_props.sv ====
// Assertions on SDRAM command timing, bound into the controller top level
`timescale 1ns/10ps

module sdramCtrlProps
    import sdramPkg::*;
#(
    parameter int refreshInterval = 390
)
(
    input logic CLK,
    input logic RESET_N,
    input logic sdrCsN,
    input logic sdrRasN,
    input logic sdrCasN,
    input logic sdrWeN,
    input logic sdrDqOe
);

    sdrCmdT cmd;
    int     sincePre;      // Cycles since last precharge
    int     sinceRef;      // Cycles since last refresh
    logic   modeDone;
    logic   readBusy;      // Read issued, precharge not yet

    assign cmd = sdrCsN ? nop : sdrCmdT'({sdrRasN, sdrCasN, sdrWeN});

    always_ff @(posedge CLK or negedge RESET_N)
    begin
        if (!RESET_N)
        begin
            sincePre <= 100;
            sinceRef <= 0;
            modeDone <= 1'b0;
            readBusy <= 1'b0;
        end
        else
        begin
            sincePre <= (cmd == precharge) ? 1 : sincePre + 1;
            sinceRef <= (cmd == autoRefresh) ? 0 : sinceRef + 1;
            if (cmd == loadMode)
                modeDone <= 1'b1;
            if (cmd == read)
                readBusy <= 1'b1;
            else if (cmd == precharge)
                readBusy <= 1'b0;
        end
    end

    assert property (@(posedge CLK) disable iff (!RESET_N)
        (cmd == active) |-> (sincePre >= tRp))
        else $error("active issued inside tRp after precharge");

    assert property (@(posedge CLK) disable iff (!RESET_N)
        readBusy |-> !sdrDqOe)
        else $error("DQ driven while read data is due");

    assert property (@(posedge CLK) disable iff (!RESET_N)
        modeDone |-> (sinceRef <= refreshInterval + tRfc + 40))
        else $error("auto-refresh overdue");

endmodule

// ==== sim/sdramCtrlTb.sv ====
// Testbench for the SDRAM controller that runs the directed tests and prints the result
`timescale 1ns/10ps

module sdramCtrlTb;
    import sdramPkg::*;

    localparam int fifoDepth       = 64;
    localparam int refreshInterval = 390;
    localparam int initDelay       = 100;
    localparam int burstLen        = 16;
    localparam int totalBursts     = 88;   // 74 write bursts plus reads and prefetch
    localparam int watchCycles     = totalBursts * (burstLen + 20) * 2 + initDelay;

    logic CLK = 1'b0;
    logic RESET_N;
    dataT wrData, rdData, sdrDqOut, sdrDqIn;
    logic wrValid, wrFull, wrLoad, rdPop, rdEmpty, rdLoad;
    wordAddrT wrStartAddr, wrMaxAddr, rdStartAddr, rdMaxAddr;
    lengthT wrLength, rdLength;
    logic [11:0] sdrAddr;
    logic [1:0] sdrBank, sdrDqm;
    logic sdrCsN, sdrCke, sdrRasN, sdrCasN, sdrWeN, sdrDqOe;

    dataT sb [wordAddrT];       // Expected SDRAM contents
    logic [31:0] lcgState = 32'd28;
    int errors = 0;
    int checks = 0;
    int testNum = 0;
    int wrWordIdx = 0;
    int rdWordIdx = 0;
    int wrBurstIdx = 0;
    int rdBurstIdx = 0;
    int wrBurstsDone = 0;
    int refreshCount = 0;
    logic finished = 1'b0;

    always #10 CLK = ~CLK;   // 20 ns period

    sdramCtrlTop #(.fifoDepth(fifoDepth), .refreshInterval(refreshInterval),
                   .initDelay(initDelay)) dut (.*);

    sdramModel memory (.*);

    bind sdramCtrlTop sdramCtrlProps #(.refreshInterval(refreshInterval)) props (
        .CLK(CLK), .RESET_N(RESET_N), .sdrCsN(sdrCsN), .sdrRasN(sdrRasN),
        .sdrCasN(sdrCasN), .sdrWeN(sdrWeN), .sdrDqOe(sdrDqOe));

    // ====================
    // Reference and compare
    // ====================

    // Address of burst k by the wrap rule
    function automatic wordAddrT refAddr(wordAddrT startAddr, wordAddrT maxAddr,
                                         lengthT len, int k);
        int n;
        n = int'(maxAddr - startAddr + 1) / int'(len);   // Bursts that fit
        if (n < 1)
            n = 1;
        return startAddr + wordAddrT'((k % n) * int'(len));
    endfunction

    function automatic logic [31:0] lcgNext(logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    task automatic checkData(string name, dataT got, dataT exp);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("** Error @ %0t: %s expected %h got %h", $time, name, exp, got);
        end
    endtask

    task automatic checkAddr(string name, wordAddrT got, wordAddrT exp);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("** Error @ %0t: %s expected %h got %h", $time, name, exp, got);
        end
    endtask

    task automatic checkBit(string name, logic got, logic exp);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("** Error @ %0t: %s expected %b got %b", $time, name, exp, got);
        end
    endtask

    // Command monitor that compares burst addresses
    always @(posedge CLK)
    begin
        sdrCmdT cmd;
        logic [1:0] actBank;
        logic [11:0] actRow;
        logic inWrite;
        logic modeSeen;
        cmd = sdrCsN ? nop : sdrCmdT'({sdrRasN, sdrCasN, sdrWeN});
        if (!RESET_N)
            modeSeen = 1'b0;
        case (cmd)
            active:
            begin
                actBank = sdrBank;
                actRow  = sdrAddr;
            end
            write:
            begin
                checkAddr("wrBurstAddr", {actBank, actRow, sdrAddr[7:0]},
                          refAddr(wrStartAddr, wrMaxAddr, wrLength, wrBurstIdx));
                wrBurstIdx++;
                inWrite = 1'b1;
            end
            read:
            begin
                checkAddr("rdBurstAddr", {actBank, actRow, sdrAddr[7:0]},
                          refAddr(rdStartAddr, rdMaxAddr, rdLength, rdBurstIdx));
                rdBurstIdx++;
                inWrite = 1'b0;
            end
            precharge: if (modeSeen && inWrite) wrBurstsDone++;
            loadMode: modeSeen = 1'b1;
            autoRefresh: if (modeSeen) refreshCount++;
            default: ;
        endcase
    end

    // ====================
    // Stimulus tasks
    // ====================
    task automatic writeWords(int n);
        wordAddrT a;
        for (int i = 0; i < n; i++)
        begin
            @(negedge CLK);
            lcgState = lcgNext(lcgState);
            wrData   = lcgState[31:16];
            wrValid  = 1'b1;
            a = refAddr(wrStartAddr, wrMaxAddr, wrLength, wrWordIdx / burstLen)
                + wordAddrT'(wrWordIdx % burstLen);
            sb[a] = wrData;
            wrWordIdx++;
            while (wrFull)      // Hold the word until taken
                @(negedge CLK);
        end
        @(negedge CLK);
        wrValid = 1'b0;
    endtask

    task automatic popWords(int n);
        wordAddrT a;
        int got;
        got = 0;
        while (got < n)
        begin
            @(negedge CLK);
            if (!rdEmpty)
            begin
                a = refAddr(rdStartAddr, rdMaxAddr, rdLength, rdWordIdx / burstLen)
                    + wordAddrT'(rdWordIdx % burstLen);
                checkData("rdData", rdData, sb.exists(a) ? sb[a] : 'x);
                rdWordIdx++;
                rdPop = 1'b1;
                got++;
            end
            else
                rdPop = 1'b0;
        end
        @(negedge CLK);
        rdPop = 1'b0;
    endtask

    task automatic loadWrite(wordAddrT startAddr, wordAddrT maxAddr);
        @(negedge CLK);
        wrStartAddr = startAddr;
        wrMaxAddr   = maxAddr;
        wrLoad      = 1'b1;
        wrWordIdx   = 0;
        wrBurstIdx  = 0;
        @(negedge CLK);
        wrLoad = 1'b0;
    endtask

    task automatic waitWrBursts(int target);
        while (wrBurstsDone < target)
            @(negedge CLK);
    endtask

    task automatic endTest(string name);
        $display("Test %0d %s finished, errors so far %0d", testNum, name, errors);
        testNum++;
    endtask

    // ====================
    // Main sequence
    // ====================
    initial
    begin
        int refStart;
        RESET_N     = 1'b0;
        wrData      = '0;
        wrValid     = 1'b0;
        wrLoad      = 1'b0;
        rdPop       = 1'b0;
        rdLoad      = 1'b0;
        wrStartAddr = 22'h000100;
        wrMaxAddr   = 22'h00013F;
        wrLength    = 8'd16;
        rdStartAddr = 22'h000100;
        rdMaxAddr   = 22'h00013F;
        rdLength    = 8'd0;
        testNum = 1;

        repeat (5)   // Reset held 5 cycles
        begin
            @(negedge CLK);
            checkBit("sdrCke", sdrCke, 1'b0);
            checkBit("sdrCsN", sdrCsN, 1'b1);
            checkBit("wrPop", dut.wrPop, 1'b0);
            checkBit("rdPush", dut.rdPush, 1'b0);
            checkBit("sdrDqOe", sdrDqOe, 1'b0);
            checkBit("rdEmpty", rdEmpty, 1'b1);
        end
        RESET_N = 1'b1;
        @(negedge CLK);
        checkBit("sdrCke", sdrCke, 1'b1);
        endTest("reset state");

        writeWords(6 * burstLen);
        waitWrBursts(6);
        endTest("write address wrap");

        @(negedge CLK);
        rdLength = 8'd16;
        rdLoad   = 1'b1;
        rdWordIdx = 0;
        rdBurstIdx = 0;
        @(negedge CLK);
        rdLoad = 1'b0;
        popWords(64);
        endTest("round-trip data");

        loadWrite(22'h000200, 22'h00023F);   // Separate region for later writes
        writeWords(4 * burstLen);
        waitWrBursts(10);
        repeat (100) @(negedge CLK);          // Read FIFO left to fill
        checkBit("rdEmpty", rdEmpty, 1'b0);
        popWords(64);
        endTest("read back-pressure");

        refStart = refreshCount;
        writeWords(62 * burstLen);
        waitWrBursts(72);
        checks++;
        if (refreshCount - refStart < 2)
        begin
            errors++;
            $display("Too few auto-refresh commands during the write traffic");
        end
        popWords(32);
        endTest("refresh during traffic");

        writeWords(burstLen);
        waitWrBursts(73);
        loadWrite(22'h000200, 22'h00023F);
        writeWords(burstLen);
        waitWrBursts(74);
        endTest("load restart");

        $display("Checks: %0d, errors: %0d", checks, errors);
        finished = 1'b1;
        if (errors == 0)
            $display("TEST PASS");
        else
            $display("TEST FAIL");
        $finish;
    end

    // Watchdog
    initial
    begin
        repeat (watchCycles) @(posedge CLK);
        finished = 1'b1;
        $display("Run stopped by watchdog after %0d cycles in test %0d", watchCycles, testNum);
        $display("TEST FAIL");
        $finish;
    end

    final
    begin
        if (!finished)
            $display("TEST FAIL");
    end

endmodule

// ==== files.f ====
hdl/sdramPkg.sv
hdl/burstFifo.sv
hdl/burstScheduler.sv
hdl/sdramSequencer.sv
hdl/sdramCtrlTop.sv
sim/sdramModel.sv
sim/sdramCtrl_props.sv
sim/sdramCtrlTb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the SDRAM controller testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module sdramCtrlTb -f files.f -o simv
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output="$(./obj_dir/simv)"
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "TEST PASS"; then
    exit 0
fi
exit 1
